//--- list.f
+incdir+design
design/mem_pkg.sv
design/rom_slot.sv
design/ram_slot.sv
design/bank_arbiter.sv
design/sdram_banks.sv
verif/sdram_banks_asserts.sv
verif/tb_sdram_banks.sv

//--- Bender.yml
package:
  name: sdram_banks

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mem_pkg.sv
      - design/rom_slot.sv
      - design/ram_slot.sv
      - design/bank_arbiter.sv
      - design/sdram_banks.sv

  - target: test
    include_dirs:
      - design
    files:
      - verif/sdram_banks_asserts.sv
      - verif/tb_sdram_banks.sv

//--- verif/tb_sdram_banks.sv
// SDRAM bank front-end testbench
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_sdram_banks;
    import mem_pkg::*;

    localparam int N_TRANS    = 320;     // ROM 40 + 40, bank 1 20, RAM 60, mix 160
    localparam int MAX_CYCLES = 400 * N_TRANS;

    logic                   clk;
    logic                   rst;
    logic                   main_ram_cs;
    logic                   main_ram_we;
    logic [`MEM_RAM_AW-1:0] main_ram_addr;
    logic [15:0]            main_ram_din;
    logic [ 1:0]            main_ram_dsn;
    logic                   main_ram_ok;
    logic [15:0]            main_ram_dout;
    logic                   main_rom_cs;
    logic [`MEM_ROM_AW-1:0] main_rom_addr;
    logic                   main_rom_ok;
    logic [15:0]            main_rom_data;
    logic                   snd_cs;
    logic [`MEM_SND_AW-1:0] snd_addr;
    logic                   snd_ok;
    logic [ 7:0]            snd_data;
    logic                   pcm_cs;
    logic [`MEM_PCM_AW-1:0] pcm_addr;
    logic                   pcm_ok;
    logic [ 7:0]            pcm_data;
    bank_req_t              ba0_req;
    bank_req_t              ba1_req;
    bank_req_t              ba3_req;
    bank_rsp_t              rsp_drv [4];     // Indexed by bank number
    sdram_word_u            data_read;

    int                     cyc;
    logic [15:0]            bank_mem [logic [23:0]];   // Bank model contents, {bank, addr}
    logic [15:0]            exp_ram  [logic [21:0]];   // Expected work RAM
    logic                   tag_v [3];                 // Main ROM, sound, PCM
    logic [20:0]            tag   [3];

    sdram_banks sdram_banks_i (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .main_ram_cs   ( main_ram_cs   ),
        .main_ram_we   ( main_ram_we   ),
        .main_ram_addr ( main_ram_addr ),
        .main_ram_din  ( main_ram_din  ),
        .main_ram_dsn  ( main_ram_dsn  ),
        .main_ram_ok   ( main_ram_ok   ),
        .main_ram_dout ( main_ram_dout ),
        .main_rom_cs   ( main_rom_cs   ),
        .main_rom_addr ( main_rom_addr ),
        .main_rom_ok   ( main_rom_ok   ),
        .main_rom_data ( main_rom_data ),
        .snd_cs        ( snd_cs        ),
        .snd_addr      ( snd_addr      ),
        .snd_ok        ( snd_ok        ),
        .snd_data      ( snd_data      ),
        .pcm_cs        ( pcm_cs        ),
        .pcm_addr      ( pcm_addr      ),
        .pcm_ok        ( pcm_ok        ),
        .pcm_data      ( pcm_data      ),
        .ba0_req       ( ba0_req       ),
        .ba1_req       ( ba1_req       ),
        .ba3_req       ( ba3_req       ),
        .ba0_rsp       ( rsp_drv[0]    ),
        .ba1_rsp       ( rsp_drv[1]    ),
        .ba3_rsp       ( rsp_drv[3]    ),
        .data_read     ( data_read     )
    );

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_half(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error @ %0t: %s read %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error @ %0t: %s read %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_req(input string what, input bank_req_t got, input bank_req_t exp);
        if (got.addr !== exp.addr || got.rd !== exp.rd || got.wr !== exp.wr) begin
            report_failure($sformatf("** Error @ %0t: %s addr %h rd %b wr %b, expected %h %b %b",
                                     $time, what, got.addr, got.rd, got.wr,
                                     exp.addr, exp.rd, exp.wr));
        end
    endtask

    // Initial memory contents, halfword a holds 3a + 5A
    function automatic logic [15:0] rule_half(input logic [21:0] a);
        return 16'(32'(a) * 32'd3 + 32'h5A);
    endfunction

    function automatic logic [15:0] model_half(input int b, input logic [21:0] a);
        logic [23:0] key;
        key = {2'(b), a};
        if (bank_mem.exists(key)) return bank_mem[key];
        return rule_half(a);
    endfunction

    function automatic logic [15:0] exp_ram_half(input logic [21:0] h);
        if (exp_ram.exists(h)) return exp_ram[h];
        return rule_half(h);
    endfunction

    function automatic logic [7:0] byte_of(input logic [15:0] w, input logic sel);
        return sel ? w[15:8] : w[7:0];   // Even byte in the low lane
    endfunction

    function automatic bank_req_t bank_req_of(input int b);
        case (b)
            0:       return ba0_req;
            1:       return ba1_req;
            default: return ba3_req;
        endcase
    endfunction

    function automatic logic [21:0] rom_haddr(input int c, input logic [20:0] a);
        case (c)
            0:       return 22'(a) + `MEM_ROM_OFFSET;
            1:       return 22'(a[15:0] >> 1);
            default: return 22'(a[17:0] >> 1) + `MEM_PCM_OFFSET;
        endcase
    endfunction

    function automatic logic predict_miss(input int c, input logic [20:0] a);
        logic [21:0] h;
        h = rom_haddr(c, a);
        return !(tag_v[c] && tag[c] == h[21:1]);
    endfunction

    function automatic logic rom_ok(input int c);
        case (c)
            0:       return main_rom_ok;
            1:       return snd_ok;
            default: return pcm_ok;
        endcase
    endfunction

    task automatic drive_rom(input int c, input logic cs, input logic [20:0] a);
        case (c)
            0: begin
                main_rom_cs   = cs;
                main_rom_addr = a;
            end
            1: begin
                snd_cs   = cs;
                snd_addr = a[15:0];
            end
            default: begin
                pcm_cs   = cs;
                pcm_addr = a[17:0];
            end
        endcase
    endtask

    // Random-latency bank, rdy only in its own turn on the shared read bus
    task automatic serve_bank(input int b);
        bank_req_t   r;
        sdram_word_u w;
        forever begin
            @(negedge clk);
            r = bank_req_of(b);
            if (!rst && (r.rd || r.wr)) begin
                repeat ($urandom_range(3, 0)) @(negedge clk);
                rsp_drv[b].ack = 1'b1;
                if (r.wr) begin
                    w.half[0] = model_half(b, r.addr);
                    if (!r.din_m[0]) w.half[0][7:0] = r.din[7:0];
                    if (!r.din_m[1]) w.half[0][15:8] = r.din[15:8];
                    bank_mem[{2'(b), r.addr}] = w.half[0];
                end
                @(negedge clk);
                rsp_drv[b].ack = 1'b0;
                repeat ($urandom_range(2, 0)) @(negedge clk);
                while (cyc % 6 != ((b == 3) ? 4 : 2 * b)) @(negedge clk);
                w.half[0] = model_half(b, r.addr);
                w.half[1] = model_half(b, r.addr + 22'd1);
                data_read = w;
                rsp_drv[b].rdy = 1'b1;
                @(negedge clk);
                rsp_drv[b].rdy = 1'b0;
                data_read = $urandom();   // Junk outside rdy
            end
        end
    endtask

    task automatic rom_read(input int c, input logic [20:0] a);
        logic [21:0] h;
        logic        miss;
        bank_req_t   exp_req;
        h    = rom_haddr(c, a);
        miss = predict_miss(c, a);
        @(negedge clk);
        drive_rom(c, 1'b1, a);
        @(negedge clk);
        if (c == 0) begin
            exp_req      = '0;
            exp_req.addr = h & ~22'd1;    // Even halfword of the pair
            exp_req.rd   = miss;
            check_req("main ROM request", ba3_req, exp_req);
        end
        if (!miss && !rom_ok(c)) begin
            report_failure("A cache hit was expected but the ROM slot did not answer at once");
        end
        while (!rom_ok(c)) @(negedge clk);
        if (c == 0) begin
            check_half("main ROM", main_rom_data, rule_half(h));
        end else if (c == 1) begin
            check_byte("sound ROM", snd_data, byte_of(rule_half(h), a[0]));
        end else begin
            check_byte("PCM ROM", pcm_data, byte_of(rule_half(h), a[0]));
        end
        drive_rom(c, 1'b0, a);
        tag_v[c] = 1'b1;
        tag[c]   = h[21:1];
    endtask

    task automatic ram_access(input logic we, input logic [`MEM_RAM_AW-1:0] a,
                              input logic [15:0] d, input logic [1:0] dsn);
        logic [21:0] h;
        logic [15:0] merged;
        bank_req_t   exp_req;
        h = 22'(a) + `MEM_RAM_OFFSET;
        @(negedge clk);
        main_ram_cs   = 1'b1;
        main_ram_we   = we;
        main_ram_addr = a;
        main_ram_din  = d;
        main_ram_dsn  = dsn;
        @(negedge clk);
        exp_req      = '0;
        exp_req.addr = h;
        exp_req.rd   = !we;
        exp_req.wr   = we;
        check_req("main RAM request", ba0_req, exp_req);
        while (!main_ram_ok) @(negedge clk);
        merged = exp_ram_half(h);
        if (we) begin
            if (!dsn[0]) merged[7:0] = d[7:0];    // dsn is active low
            if (!dsn[1]) merged[15:8] = d[15:8];
            exp_ram[h] = merged;
        end else begin
            check_half("main RAM", main_ram_dout, merged);
        end
        main_ram_cs = 1'b0;   // Low for at least a cycle before the next access
    endtask

    task automatic ram_mix(input int n);
        repeat (n) begin
            repeat ($urandom_range(3, 0)) @(negedge clk);
            ram_access(1'($urandom_range(1, 0)), `MEM_RAM_AW'($urandom_range(15, 0)),
                       16'($urandom()), 2'($urandom()));
        end
    endtask

    task automatic rom_mix(input int c, input int n);
        repeat (n) begin
            repeat ($urandom_range(3, 0)) @(negedge clk);
            rom_read(c, 21'($urandom_range((c == 0) ? 31 : 127, 0)));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial serve_bank(0);
    initial serve_bank(1);
    initial serve_bank(3);

    // Cycle count for the bank turns and the run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > MAX_CYCLES) begin
            report_failure("Timeout: the run did not finish within the cycle limit");
        end
        if (sdram_banks_i.asserts_i.fail_cnt != 0) begin
            report_failure("A bank handshake assertion failed");
        end
    end

    initial begin
        bank_req_t   exp_req;
        logic [20:0] sa;
        logic [20:0] pa;
        logic [20:0] a;
        void'($urandom(53));
        cyc           = 0;
        rst           = 1'b1;
        main_ram_cs   = 1'b0;
        main_ram_we   = 1'b0;
        main_ram_addr = '0;
        main_ram_din  = '0;
        main_ram_dsn  = 2'b11;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        snd_cs        = 1'b0;
        snd_addr      = '0;
        pcm_cs        = 1'b0;
        pcm_addr      = '0;
        data_read     = '0;
        for (int i = 0; i < 4; i++) rsp_drv[i] = '0;
        for (int i = 0; i < 3; i++) tag_v[i] = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (40) rom_read(0, 21'($urandom()));   // Whole main ROM space
        repeat (20) begin                           // Second half of a fetched line
            a = 21'($urandom());
            rom_read(0, a);
            rom_read(0, a ^ 21'd1);
        end

        // Sound and PCM start together, sound owns bank 1 first
        repeat (10) begin
            sa = 21'(16'($urandom()));
            pa = 21'(18'($urandom()));
            if (!predict_miss(1, sa)) sa = sa ^ 21'h100;
            if (!predict_miss(2, pa)) pa = pa ^ 21'h100;
            fork
                rom_read(1, sa);
                rom_read(2, pa);
                begin
                    repeat (2) @(negedge clk);
                    exp_req      = '0;
                    exp_req.addr = rom_haddr(1, sa) & ~22'd1;
                    exp_req.rd   = 1'b1;
                    check_req("bank 1 grant", ba1_req, exp_req);
                    // PCM takes the bank right after the sound data returns
                    do @(posedge clk); while (!rsp_drv[1].rdy);
                    @(negedge clk);
                    exp_req.addr = rom_haddr(2, pa) & ~22'd1;
                    check_req("bank 1 second grant", ba1_req, exp_req);
                end
            join
        end

        repeat (30) begin   // Masked write, then read back
            a = 21'($urandom_range(15, 0));
            ram_access(1'b1, a[16:0], 16'($urandom()), 2'($urandom()));
            ram_access(1'b0, a[16:0], 16'h0, 2'b00);
        end

        fork
            ram_mix(40);
            rom_mix(0, 40);
            rom_mix(1, 40);
            rom_mix(2, 40);
        join
        repeat (4) @(negedge clk);

        if (sdram_banks_i.asserts_i.fail_cnt != 0) begin
            report_failure("A bank handshake assertion failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- verif/sdram_banks_asserts.sv
// Bank handshake assertions
`timescale 1ns/1ps

module sdram_banks_asserts (
    input logic               clk,
    input logic               rst,
    input mem_pkg::bank_req_t ba0_req,
    input mem_pkg::bank_req_t ba1_req,
    input mem_pkg::bank_req_t ba3_req,
    input mem_pkg::bank_rsp_t ba0_rsp,
    input mem_pkg::bank_rsp_t ba1_rsp,
    input mem_pkg::bank_rsp_t ba3_rsp,
    input logic [3:0]         cs,       // RAM, main ROM, sound, PCM
    input logic [3:0]         ok
);
    import mem_pkg::*;

    int fail_cnt = 0;

    // Request stays up until the bank takes it
    property p_held(bank_req_t r, bank_rsp_t s);
        @(posedge clk) disable iff (rst)
            ((r.rd && !s.ack) |=> r.rd) and ((r.wr && !s.ack) |=> r.wr);
    endproperty

    a_ba0_held: assert property (p_held(ba0_req, ba0_rsp)) else begin
        $error("Bank 0 request dropped before ack");
        fail_cnt++;
    end

    a_ba1_held: assert property (p_held(ba1_req, ba1_rsp)) else begin
        $error("Bank 1 request dropped before ack");
        fail_cnt++;
    end

    a_ba3_held: assert property (p_held(ba3_req, ba3_rsp)) else begin
        $error("Bank 3 request dropped before ack");
        fail_cnt++;
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(ba0_req.rd && ba0_req.wr) && !(ba1_req.rd && ba1_req.wr) &&
        !(ba3_req.rd && ba3_req.wr)) else begin
        $error("rd and wr high together on a bank");
        fail_cnt++;
    end

    a_ok_needs_cs: assert property (@(posedge clk) disable iff (rst)
        (ok & ~cs) == 4'b0) else begin
        $error("Client ok high without its cs");
        fail_cnt++;
    end

endmodule

bind sdram_banks sdram_banks_asserts asserts_i (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .ba0_req ( ba0_req ),
    .ba1_req ( ba1_req ),
    .ba3_req ( ba3_req ),
    .ba0_rsp ( ba0_rsp ),
    .ba1_rsp ( ba1_rsp ),
    .ba3_rsp ( ba3_rsp ),
    .cs      ( {main_ram_cs, main_rom_cs, snd_cs, pcm_cs} ),
    .ok      ( {main_ram_ok, main_rom_ok, snd_ok, pcm_ok} )
);

//--- design/sdram_banks.sv
// SDRAM bank front-end
`timescale 1ns/1ps
`include "mem_consts.svh"

module sdram_banks (
    input  logic                      clk,
    input  logic                      rst,

    // Main CPU work RAM
    input  logic                      main_ram_cs,
    input  logic                      main_ram_we,
    input  logic [`MEM_RAM_AW-1:0]    main_ram_addr,
    input  logic [15:0]               main_ram_din,
    input  logic [ 1:0]               main_ram_dsn,
    output logic                      main_ram_ok,
    output logic [15:0]               main_ram_dout,

    // Main CPU program
    input  logic                      main_rom_cs,
    input  logic [`MEM_ROM_AW-1:0]    main_rom_addr,
    output logic                      main_rom_ok,
    output logic [15:0]               main_rom_data,

    // Sound CPU program
    input  logic                      snd_cs,
    input  logic [`MEM_SND_AW-1:0]    snd_addr,
    output logic                      snd_ok,
    output logic [ 7:0]               snd_data,

    // PCM samples
    input  logic                      pcm_cs,
    input  logic [`MEM_PCM_AW-1:0]    pcm_addr,
    output logic                      pcm_ok,
    output logic [ 7:0]               pcm_data,

    // Bank ports
    output mem_pkg::bank_req_t        ba0_req,
    output mem_pkg::bank_req_t        ba1_req,
    output mem_pkg::bank_req_t        ba3_req,
    input  mem_pkg::bank_rsp_t        ba0_rsp,
    input  mem_pkg::bank_rsp_t        ba1_rsp,
    input  mem_pkg::bank_rsp_t        ba3_rsp,
    input  mem_pkg::sdram_word_u      data_read
);
    import mem_pkg::*;

    bank_req_t snd_req;
    bank_req_t pcm_req;
    bank_rsp_t snd_rsp;
    bank_rsp_t pcm_rsp;

    // Bank 0, read/write
    ram_slot #(.AW(`MEM_RAM_AW)) u_ram (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .cs        ( main_ram_cs   ),
        .we        ( main_ram_we   ),
        .addr      ( main_ram_addr ),
        .din       ( main_ram_din  ),
        .dsn       ( main_ram_dsn  ),
        .ok        ( main_ram_ok   ),
        .dout      ( main_ram_dout ),
        .req       ( ba0_req       ),
        .rsp       ( ba0_rsp       ),
        .data_read ( data_read     )
    );

    // Bank 1, sound program at zero
    rom_slot #(.AW(`MEM_SND_AW), .DW(8), .OFFSET(22'h0)) u_snd (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .cs        ( snd_cs        ),
        .addr      ( snd_addr      ),
        .ok        ( snd_ok        ),
        .dout      ( snd_data      ),
        .req       ( snd_req       ),
        .rsp       ( snd_rsp       ),
        .data_read ( data_read     )
    );

    rom_slot #(.AW(`MEM_PCM_AW), .DW(8), .OFFSET(`MEM_PCM_OFFSET)) u_pcm (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .cs        ( pcm_cs        ),
        .addr      ( pcm_addr      ),
        .ok        ( pcm_ok        ),
        .dout      ( pcm_data      ),
        .req       ( pcm_req       ),
        .rsp       ( pcm_rsp       ),
        .data_read ( data_read     )
    );

    bank_arbiter u_ba1_arb (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .req0      ( snd_req       ),   // Sound first
        .req1      ( pcm_req       ),
        .rsp0      ( snd_rsp       ),
        .rsp1      ( pcm_rsp       ),
        .bank_req  ( ba1_req       ),
        .bank_rsp  ( ba1_rsp       )
    );

    // Bank 3, main CPU program
    rom_slot #(.AW(`MEM_ROM_AW), .DW(16), .OFFSET(`MEM_ROM_OFFSET)) u_rom (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .cs        ( main_rom_cs   ),
        .addr      ( main_rom_addr ),
        .ok        ( main_rom_ok   ),
        .dout      ( main_rom_data ),
        .req       ( ba3_req       ),
        .rsp       ( ba3_rsp       ),
        .data_read ( data_read     )
    );

endmodule

//--- design/bank_arbiter.sv
// Two-slot bank arbiter
`timescale 1ns/1ps

module bank_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::bank_req_t req0,      // Higher priority
    input  mem_pkg::bank_req_t req1,
    output mem_pkg::bank_rsp_t rsp0,
    output mem_pkg::bank_rsp_t rsp1,
    output mem_pkg::bank_req_t bank_req,
    input  mem_pkg::bank_rsp_t bank_rsp
);
    import mem_pkg::*;

    logic      busy_q;
    logic      owner_q;
    logic      acked_q;    // Owner request already taken by the bank
    logic      act0;
    logic      act1;
    logic      gnt;        // Slot currently facing the bank
    logic      live;
    bank_req_t granted;

    assign act0 = req0.rd || req0.wr;
    assign act1 = req1.rd || req1.wr;

    // Slot 0 wins when idle
    assign gnt  = busy_q ? owner_q : !act0;
    assign live = busy_q || act0 || act1;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            acked_q <= 1'b0;
        end else if (!busy_q) begin
            if (act0 || act1) begin
                busy_q  <= 1'b1;
                owner_q <= gnt;
                acked_q <= bank_rsp.ack;
            end
        end else begin
            if (bank_rsp.ack) begin
                acked_q <= 1'b1;
            end
            if (bank_rsp.rdy) begin   // Grant frees with the data
                busy_q  <= 1'b0;
                acked_q <= 1'b0;
            end
        end
    end

    // Only the owner reaches the bank
    always_comb begin
        granted = gnt ? req1 : req0;
        if (acked_q) begin
            granted.rd = 1'b0;
            granted.wr = 1'b0;
        end
        bank_req = granted;
    end

    // ack and rdy back to the owner only
    always_comb begin
        rsp0 = '0;
        rsp1 = '0;
        if (live) begin
            if (gnt) begin
                rsp1 = bank_rsp;
            end else begin
                rsp0 = bank_rsp;
            end
        end
    end

endmodule

//--- design/ram_slot.sv
// Work RAM client slot
`timescale 1ns/1ps
`include "mem_consts.svh"

module ram_slot #(
    parameter int AW = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cs,
    input  logic                 we,
    input  logic [AW-1:0]        addr,
    input  logic [15:0]          din,
    input  logic [ 1:0]          dsn,     // Active low byte enables
    output logic                 ok,
    output logic [15:0]          dout,
    output mem_pkg::bank_req_t   req,
    input  mem_pkg::bank_rsp_t   rsp,
    input  mem_pkg::sdram_word_u data_read
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t      state_q;
    logic        we_q;
    logic [21:0] addr_q;
    logic [15:0] din_q;
    logic [ 1:0] dsn_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cs) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (rsp.ack) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp.rdy) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    if (!cs) begin
                        state_q <= ST_IDLE;   // Client released
                    end
                end
            endcase
        end
    end

    // Access parameters captured as the request starts
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && cs) begin
            we_q   <= we;
            addr_q <= 22'(addr) + `MEM_RAM_OFFSET;
            din_q  <= din;
            dsn_q  <= dsn;
        end
        if (state_q == ST_WAIT && rsp.rdy && !we_q) begin
            dout <= data_read.half[0];
        end
    end

    always_comb begin
        req.addr  = addr_q;
        req.rd    = (state_q == ST_REQ) && !we_q;
        req.wr    = (state_q == ST_REQ) && we_q;
        req.din   = din_q;
        req.din_m = dsn_q;
    end

    assign ok = cs && (state_q == ST_DONE);

endmodule

//--- design/rom_slot.sv
// Read-only client slot
`timescale 1ns/1ps

module rom_slot #(
    parameter int          AW     = 16,
    parameter int          DW     = 8,      // 8 or 16
    parameter logic [21:0] OFFSET = 22'h0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    output logic                 ok,
    output logic [DW-1:0]        dout,
    output mem_pkg::bank_req_t   req,
    input  mem_pkg::bank_rsp_t   rsp,
    input  mem_pkg::sdram_word_u data_read
);
    import mem_pkg::*;

    // Byte clients address halfwords without their lowest bit
    localparam int SHIFT = (DW == 8) ? 1 : 0;

    logic [21:0] haddr;
    logic        hit;
    logic        start;
    logic        rd_q;
    logic        wait_q;      // Acked, data still to come
    logic        valid_q;
    logic [20:0] fill_tag_q;  // Pair being fetched
    logic [20:0] tag_q;       // Pair held in the line
    sdram_word_u line_q;

    assign haddr = 22'(addr >> SHIFT) + OFFSET;
    assign hit   = valid_q && (tag_q == haddr[21:1]);
    assign ok    = cs && hit;    // Drops as soon as the address leaves the line
    assign start = cs && !hit && !rd_q && !wait_q;

    // Miss sequence: rd until ack, then wait for rdy
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_q    <= 1'b0;
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (rd_q) begin
                if (rsp.ack) begin
                    rd_q   <= 1'b0;
                    wait_q <= 1'b1;
                end
            end else if (wait_q) begin
                if (rsp.rdy) begin
                    wait_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end else if (start) begin
                rd_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fill_tag_q <= haddr[21:1];
        end
        if (wait_q && rsp.rdy) begin
            line_q <= data_read;   // Both halfwords of the pair
            tag_q  <= fill_tag_q;
        end
    end

    // Always an even halfword, so the pair lands in one line
    always_comb begin
        req       = '0;
        req.addr  = {fill_tag_q, 1'b0};
        req.rd    = rd_q;
        req.din_m = 2'b11;
    end

    generate
        if (DW == 8) begin : g_byte
            // Even byte address in the low lane of each half
            assign dout = line_q.lane[{haddr[0], addr[0]}];
        end else begin : g_half
            assign dout = line_q.half[haddr[0]];
        end
    endgenerate

endmodule

//--- design/mem_pkg.sv
// SDRAM bank types
package mem_pkg;

    // Request from a slot towards one SDRAM bank
    typedef struct packed {
        logic [21:0] addr;     // Halfword address
        logic        rd;
        logic        wr;       // Always low from read-only slots
        logic [15:0] din;      // Write data
        logic [ 1:0] din_m;    // Byte write mask, active low
    } bank_req_t;

    // Controller answer for one bank
    typedef struct packed {
        logic ack;    // Request taken
        logic rdy;    // One-cycle pulse, data_read valid
    } bank_rsp_t;

    // Shared read word, halfword at the requested address sits in half 0
    // 16-bit clients pick a half, 8-bit clients pick a byte lane
    typedef union packed {
        logic [1:0][15:0] half;
        logic [3:0][ 7:0] lane;
    } sdram_word_u;

endpackage

//--- design/mem_consts.svh
// SDRAM bank constants
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Halfword base offsets inside a bank
// Main work RAM in bank 0
`define MEM_RAM_OFFSET 22'h08_0000
// PCM samples share bank 1 with the sound program, which starts at zero
`define MEM_PCM_OFFSET 22'h10_0000
// Main CPU program in bank 3
`define MEM_ROM_OFFSET 22'h20_0000

// Client address widths
// Sound CPU, byte address
`define MEM_SND_AW 16
// PCM samples, byte address
`define MEM_PCM_AW 18
// Main CPU program, halfword address
`define MEM_ROM_AW 21
// Main work RAM, halfword address
`define MEM_RAM_AW 17

`endif
